// File: verilog/lsu_pkg.sv
package lsu_pkg;

    // widths
    localparam int XLEN  = 32;  // data and address width
    localparam int IMM_W = 12;  // I/S-type immediate width

    // funct3 access size
    // bit 2 set means zero extension on loads
    // 011, 110, 111 are illegal, loads treat them as word accesses
    typedef enum logic [2:0] {
        OP_B  = 3'b000,  // lb / sb
        OP_H  = 3'b001,  // lh / sh
        OP_W  = 3'b010,  // lw / sw
        OP_BU = 3'b100,  // lbu
        OP_HU = 3'b101   // lhu
    } mem_op_e;

    // request leaving address generation
    // addr is the full effective address, wrapping happens in the memory
    typedef struct packed {
        logic            valid;       // one cycle per request
        logic            we;          // store
        mem_op_e         op;          // access size and extension
        logic [XLEN-1:0] addr;        // base + sext(offset)
        logic [XLEN-1:0] wdata;       // store data, low lanes used for sb/sh
        logic            misaligned;  // access is dropped downstream
    } lsu_req_t;

    // response leaving the data memory
    // raw holds bytes addr..addr+3, byte at addr in bits 7:0
    typedef struct packed {
        logic            valid;
        logic            we;
        mem_op_e         op;
        logic            misaligned;
        logic [XLEN-1:0] raw;
    } lsu_rsp_t;

    // add x0, x0, x0
    // every memory word holds this after reset
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0033;

endpackage

// File: verilog/lsu_agen.sv
`timescale 1ns/1ns

module lsu_agen #(
    parameter int MEM_BYTES = 512
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid_i,  // one-cycle request pulse
    input  logic                      req_we_i,     // 1 for store
    input  lsu_pkg::mem_op_e          req_op_i,     // funct3
    input  logic [lsu_pkg::XLEN-1:0]  base_i,       // rs1 value
    input  logic [lsu_pkg::IMM_W-1:0] offset_i,     // signed immediate
    input  logic [lsu_pkg::XLEN-1:0]  wdata_i,      // rs2 value for stores
    output lsu_pkg::lsu_req_t         req_o
);
    import lsu_pkg::*;

    // memory size must allow byte wrapping on the low address bits
    if (MEM_BYTES < 16 || (MEM_BYTES & (MEM_BYTES - 1)) != 0) begin : g_size_chk
        $error("lsu_agen: MEM_BYTES must be a power of two of at least 16");
    end

    logic [XLEN-1:0] off_ext;     // sign-extended offset
    logic [XLEN-1:0] ea;          // effective address
    logic            misaligned;

    // stage 1 registers
    logic            valid_q;
    logic            we_q;
    mem_op_e         op_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] wdata_q;
    logic            mis_q;

    assign off_ext = {{(XLEN-IMM_W){offset_i[IMM_W-1]}}, offset_i};
    assign ea      = base_i + off_ext;  // carry out dropped

    // alignment by access size
    always_comb begin
        case (req_op_i)
            OP_B, OP_BU: misaligned = 1'b0;       // bytes always fit
            OP_H, OP_HU: misaligned = ea[0];
            default:     misaligned = |ea[1:0];   // word and illegal codes
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid_i;
        end
    end

    // payload follows valid every cycle
    always_ff @(posedge clk) begin
        we_q    <= req_we_i;
        op_q    <= req_op_i;
        addr_q  <= ea;
        wdata_q <= wdata_i;
        mis_q   <= misaligned;
    end

    assign req_o = '{valid: valid_q, we: we_q, op: op_q, addr: addr_q,
                     wdata: wdata_q, misaligned: mis_q};

    // stores come only as sb, sh or sw from the decoder
    a_store_op: assert property (@(posedge clk) disable iff (rst)
        req_valid_i && req_we_i |-> req_op_i inside {OP_B, OP_H, OP_W})
        else $error("lsu_agen: store issued with funct3 %b", req_op_i);

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/1ns

module data_mem #(
    parameter int MEM_BYTES = 512
) (
    input  logic              clk,
    input  logic              rst,
    input  lsu_pkg::lsu_req_t req_i,  // from address generation
    output lsu_pkg::lsu_rsp_t rsp_o   // to load alignment
);
    import lsu_pkg::*;

    localparam int AW = $clog2(MEM_BYTES);  // byte index width

    logic [7:0]      mem [MEM_BYTES];  // little-endian byte store
    logic [AW-1:0]   a0;               // wrapped byte address
    logic [3:0]      be;               // byte lanes to write
    logic            wr_en;
    logic [XLEN-1:0] rd_word;          // bytes a0..a0+3

    // stage 2 registers
    logic            valid_q;
    logic            we_q;
    mem_op_e         op_q;
    logic            mis_q;
    logic [XLEN-1:0] raw_q;

    assign a0    = req_i.addr[AW-1:0];  // upper bits ignored, addresses wrap
    assign wr_en = req_i.valid && req_i.we && !req_i.misaligned;

    // lanes per access size
    always_comb begin
        case (req_i.op)
            OP_B, OP_BU: be = 4'b0001;
            OP_H, OP_HU: be = 4'b0011;
            default:     be = 4'b1111;  // sw, illegal codes as word
        endcase
    end

    // four consecutive bytes, wrapping at the top of memory
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rd_word[8*k +: 8] = mem[a0 + AW'(k)];
        end
    end

    // memory and valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // NOP in every word, byte 0 holds 0x33
            for (int i = 0; i < MEM_BYTES; i++) begin
                mem[i] <= NOP_WORD[8*(i%4) +: 8];
            end
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
            if (wr_en) begin
                for (int k = 0; k < 4; k++) begin
                    if (be[k]) begin
                        mem[a0 + AW'(k)] <= req_i.wdata[8*k +: 8];  // lane k to addr+k
                    end
                end
            end
        end
    end

    // read samples the array before this edge's write lands
    always_ff @(posedge clk) begin
        we_q  <= req_i.we;
        op_q  <= req_i.op;
        mis_q <= req_i.misaligned;
        raw_q <= rd_word;
    end

    assign rsp_o = '{valid: valid_q, we: we_q, op: op_q, misaligned: mis_q, raw: raw_q};

    // flag from stage 1 must agree with the address it carries
    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        req_i.valid && !req_i.misaligned
            && !(req_i.op inside {OP_B, OP_BU, OP_H, OP_HU})
        |-> req_i.addr[1:0] == 2'b00)
        else $error("data_mem: word access at %h not flagged misaligned", req_i.addr);

endmodule

// File: verilog/load_align.sv
`timescale 1ns/1ns

module load_align (
    input  logic                     clk,
    input  logic                     rst,
    input  lsu_pkg::lsu_rsp_t        rsp_i,             // raw bytes from memory
    output logic                     rsp_valid_o,       // one pulse per request
    output logic [lsu_pkg::XLEN-1:0] rsp_data_o,        // load result, 0 for stores
    output logic                     rsp_misaligned_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0] ext;     // extended load value
    logic [XLEN-1:0] data_d;

    // raw[7:0] is always the byte at addr
    always_comb begin
        case (rsp_i.op)
            OP_B:    ext = {{(XLEN-8){rsp_i.raw[7]}}, rsp_i.raw[7:0]};
            OP_BU:   ext = {{(XLEN-8){1'b0}}, rsp_i.raw[7:0]};
            OP_H:    ext = {{(XLEN-16){rsp_i.raw[15]}}, rsp_i.raw[15:0]};
            OP_HU:   ext = {{(XLEN-16){1'b0}}, rsp_i.raw[15:0]};
            default: ext = rsp_i.raw;  // lw, illegal codes
        endcase
    end

    // stores and misaligned accesses return zero
    assign data_d = (rsp_i.we || rsp_i.misaligned) ? '0 : ext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid_o      <= 1'b0;
            rsp_misaligned_o <= 1'b0;
        end else begin
            rsp_valid_o      <= rsp_i.valid;
            rsp_misaligned_o <= rsp_i.valid && rsp_i.misaligned;  // only with a response
        end
    end

    always_ff @(posedge clk) begin
        rsp_data_o <= data_d;
    end

    // a single byte never straddles a boundary
    a_byte_aligned: assert property (@(posedge clk) disable iff (rst)
        rsp_i.valid && rsp_i.misaligned |-> !(rsp_i.op inside {OP_B, OP_BU}))
        else $error("load_align: byte access arrived flagged misaligned");

endmodule

// File: verilog/lsu_top.sv
`timescale 1ns/1ns

module lsu_top #(
    parameter int MEM_BYTES = 512  // data memory size in bytes
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid_i,
    input  logic                      req_we_i,
    input  lsu_pkg::mem_op_e          req_op_i,
    input  logic [lsu_pkg::XLEN-1:0]  base_i,
    input  logic [lsu_pkg::IMM_W-1:0] offset_i,
    input  logic [lsu_pkg::XLEN-1:0]  wdata_i,
    output logic                      rsp_valid_o,
    output logic [lsu_pkg::XLEN-1:0]  rsp_data_o,
    output logic                      rsp_misaligned_o
);
    import lsu_pkg::*;

    lsu_req_t req;  // stage 1 -> 2
    lsu_rsp_t rsp;  // stage 2 -> 3

    // stage 1, address and alignment
    lsu_agen #(.MEM_BYTES(MEM_BYTES)) u_agen (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_op_i    (req_op_i),
        .base_i      (base_i),
        .offset_i    (offset_i),
        .wdata_i     (wdata_i),
        .req_o       (req)
    );

    // stage 2, byte memory
    data_mem #(.MEM_BYTES(MEM_BYTES)) u_mem (
        .clk   (clk),
        .rst   (rst),
        .req_i (req),
        .rsp_o (rsp)
    );

    // stage 3, extension and outputs
    load_align u_align (
        .clk              (clk),
        .rst              (rst),
        .rsp_i            (rsp),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_data_o       (rsp_data_o),
        .rsp_misaligned_o (rsp_misaligned_o)
    );

endmodule

// File: testbench/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb;
    import lsu_pkg::*;

    localparam int MEM_BYTES = 512;
    localparam int CLK_HALF  = 20;   // 40 ns period
    localparam int DRV_DLY   = 2;    // input skew after posedge
    localparam int LATENCY   = 3;    // drive cycle to response cycle
    localparam int DRAIN_MAX = 20;   // cycles allowed for the pipe to empty

    logic             clk;
    logic             rst;
    logic             req_valid;
    logic             req_we;
    mem_op_e          req_op;
    logic [XLEN-1:0]  base;
    logic [IMM_W-1:0] offset;
    logic [XLEN-1:0]  wdata;
    logic             rsp_valid;
    logic [XLEN-1:0]  rsp_data;
    logic             rsp_mis;

    logic [7:0]      ref_mem [MEM_BYTES];  // reference byte model
    logic [XLEN-1:0] exp_data_q [$];       // expected results in issue order
    logic            exp_mis_q  [$];
    int              exp_cyc_q  [$];       // issue cycle per request
    logic [31:0]     lfsr_state;
    int              cyc = 0;
    int              errors = 0;
    int              checks = 0;
    int              timeouts = 0;
    int              n_req = 0;
    int              n_rsp = 0;

    lsu_top #(.MEM_BYTES(MEM_BYTES)) DUT (
        .clk              (clk),
        .rst              (rst),
        .req_valid_i      (req_valid),
        .req_we_i         (req_we),
        .req_op_i         (req_op),
        .base_i           (base),
        .offset_i         (offset),
        .wdata_i          (wdata),
        .rsp_valid_o      (rsp_valid),
        .rsp_data_o       (rsp_data),
        .rsp_misaligned_o (rsp_mis)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;  // cycle stamp for latency

    // galois lfsr, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic int access_bytes(input mem_op_e op);
        case (op)
            OP_B, OP_BU: return 1;
            OP_H, OP_HU: return 2;
            default:     return 4;  // word and illegal codes
        endcase
    endfunction

    // little-endian read of the model, then extension by funct3
    function automatic logic [XLEN-1:0] model_load(input mem_op_e op,
                                                   input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = ref_mem[(addr + k) % MEM_BYTES];  // wraps at top
        end
        case (op)
            OP_B:    return {{24{w[7]}}, w[7:0]};
            OP_BU:   return {24'h0, w[7:0]};
            OP_H:    return {{16{w[15]}}, w[15:0]};
            OP_HU:   return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // one request for one cycle, model updated in issue order
    task automatic issue(input logic we, input mem_op_e op, input logic [XLEN-1:0] b,
                         input logic [IMM_W-1:0] off, input logic [XLEN-1:0] d);
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] exp;
        logic            mis;
        int              n;
        addr = b + {{(XLEN-IMM_W){off[IMM_W-1]}}, off};  // sext offset
        n    = access_bytes(op);
        mis  = (addr % n) != 0;
        if (we && !mis) begin
            for (int k = 0; k < n; k++) begin
                ref_mem[(addr + k) % MEM_BYTES] = d[8*k +: 8];
            end
        end
        exp = (we || mis) ? 32'h0 : model_load(op, addr);
        exp_data_q.push_back(exp);
        exp_mis_q.push_back(mis);
        exp_cyc_q.push_back(cyc);
        req_valid = 1'b1;
        req_we    = we;
        req_op    = op;
        base      = b;
        offset    = off;
        wdata     = d;
        n_req++;
        @(posedge clk);
        #DRV_DLY;
        req_valid = 1'b0;
    endtask

    // bounded wait until every issued request has answered
    task automatic wait_drain(input string name);
        int n;
        n = 0;
        while (exp_data_q.size() != 0 && n < DRAIN_MAX) begin
            @(posedge clk);
            n++;
        end
        if (exp_data_q.size() != 0) begin
            timeouts++;
            $display("timeout in %s: %0d responses still missing after %0d cycles",
                     name, exp_data_q.size(), DRAIN_MAX);
            exp_data_q.delete();
            exp_mis_q.delete();
            exp_cyc_q.delete();
        end
        @(posedge clk);
        #DRV_DLY;
    endtask

    // outputs settle after posedge, sample mid cycle
    initial begin
        int lat;
        forever begin
            @(negedge clk);
            if (!rst && rsp_valid) begin
                n_rsp++;
                if (exp_data_q.size() == 0) begin
                    errors++;
                    $display("t=%0t a response came out with no request outstanding", $time);
                end else begin
                    check_data(rsp_data, exp_data_q.pop_front(), "rsp_data_o");
                    check_flag(rsp_mis, exp_mis_q.pop_front(), "rsp_misaligned_o");
                    lat = cyc - exp_cyc_q.pop_front();
                    if (lat != LATENCY) begin
                        errors++;
                        $display("t=%0t response took %0d cycles instead of %0d",
                                 $time, lat, LATENCY);
                    end
                end
            end
        end
    end

    task automatic test_reset_contents();
        issue(1'b0, OP_W, 32'h000, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h040, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h100, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h1fc, 12'h0, 32'h0);
        issue(1'b0, OP_BU, 32'h000, 12'h1, 32'h0);  // upper nop byte is zero
        wait_drain("reset contents");
    endtask

    task automatic test_word_round_trip();
        issue(1'b1, OP_W, 32'h080, 12'h0, 32'hdead_beef);
        issue(1'b0, OP_W, 32'h080, 12'h0, 32'h0);        // next cycle sees new word
        issue(1'b1, OP_W, 32'h084, 12'h0, 32'h0bad_f00d);
        issue(1'b0, OP_W, 32'h080, 12'h4, 32'h0);
        wait_drain("word round trip");
    endtask

    task automatic test_partial_stores();
        logic [7:0]  bval;
        logic [15:0] hval;
        for (int lane = 0; lane < 4; lane++) begin
            bval = 8'h80 + 8'(lane * 23);                // top bit always set
            issue(1'b1, OP_B, 32'h20, 12'(lane), {24'ha5a5a5, bval});
        end
        for (int lane = 0; lane < 4; lane += 2) begin
            hval = 16'h8000 + 16'(lane * 16'h1357);
            issue(1'b1, OP_H, 32'h30, 12'(lane), {16'h5a5a, hval});
        end
        for (int lane = 0; lane < 4; lane++) begin
            issue(1'b0, OP_B, 32'h20, 12'(lane), 32'h0);
            issue(1'b0, OP_BU, 32'h20, 12'(lane), 32'h0);
            issue(1'b0, OP_B, 32'h30, 12'(lane), 32'h0);
            issue(1'b0, OP_BU, 32'h30, 12'(lane), 32'h0);
        end
        for (int lane = 0; lane < 4; lane += 2) begin
            issue(1'b0, OP_H, 32'h20, 12'(lane), 32'h0);
            issue(1'b0, OP_HU, 32'h20, 12'(lane), 32'h0);
            issue(1'b0, OP_H, 32'h30, 12'(lane), 32'h0);
            issue(1'b0, OP_HU, 32'h30, 12'(lane), 32'h0);
        end
        // neighbours keep their nop
        issue(1'b0, OP_W, 32'h1c, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h20, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h24, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h2c, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h30, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h34, 12'h0, 32'h0);
        wait_drain("partial stores");
    endtask

    task automatic test_misalign();
        issue(1'b1, OP_H, 32'h51, 12'h0, 32'hffff_ffff);
        issue(1'b1, OP_H, 32'h53, 12'h0, 32'hffff_ffff);
        issue(1'b1, OP_W, 32'h61, 12'h0, 32'hffff_ffff);
        issue(1'b1, OP_W, 32'h62, 12'h0, 32'hffff_ffff);
        issue(1'b1, OP_W, 32'h63, 12'h0, 32'hffff_ffff);
        issue(1'b0, OP_W, 32'h42, 12'h0, 32'h0);
        issue(1'b0, OP_H, 32'h45, 12'h0, 32'h0);
        issue(1'b0, OP_HU, 32'h47, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h50, 12'h0, 32'h0);     // untouched words
        issue(1'b0, OP_W, 32'h54, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h60, 12'h0, 32'h0);
        issue(1'b0, OP_W, 32'h64, 12'h0, 32'h0);
        wait_drain("misalignment");
    endtask

    task automatic test_addr_arith();
        issue(1'b1, OP_W, 32'h0000_0a00, 12'hff8, 32'h1357_9bdf);  // 0x9f8 wraps to 0x1f8
        issue(1'b0, OP_W, 32'h0000_01f0, 12'h008, 32'h0);
        issue(1'b0, OP_W, 32'h0000_0200, 12'hff8, 32'h0);
        issue(1'b0, OP_W, 32'h0000_0000, 12'hff8, 32'h0);          // below zero
        issue(1'b1, OP_B, 32'h0001_0003, 12'h800, 32'h0000_00c3);  // most negative offset
        issue(1'b0, OP_BU, 32'h0000_0000, 12'h603, 32'h0);
        issue(1'b0, OP_B, 32'h7fff_fe00, 12'h403, 32'h0);
        wait_drain("address arithmetic");
    endtask

    task automatic test_random_stream(input int count);
        logic             we;
        mem_op_e          op;
        logic [XLEN-1:0]  b;
        logic [XLEN-1:0]  d;
        logic [IMM_W-1:0] off;
        logic [2:0]       sel;
        for (int i = 0; i < count; i++) begin
            we = 1'(random_bits(1));
            if (we) begin
                sel = 3'(random_bits(2));
                op  = (sel == 0) ? OP_B : (sel == 1) ? OP_H : OP_W;  // legal stores
            end else begin
                sel = 3'(random_bits(3));
                case (sel)
                    3'd0:    op = OP_B;
                    3'd1:    op = OP_H;
                    3'd3:    op = OP_BU;
                    3'd4:    op = OP_HU;
                    default: op = OP_W;
                endcase
            end
            b   = random_bits(32);
            off = IMM_W'(random_bits(IMM_W));
            d   = random_bits(32);
            if (random_bits(2) != 0) begin  // mostly aligned traffic
                b[1:0]   = 2'b00;
                off[1:0] = 2'b00;
            end
            issue(we, op, b, off, d);
        end
        wait_drain("random stream");
    endtask

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_we     = 1'b0;
        req_op     = OP_B;
        base       = '0;
        offset     = '0;
        wdata      = '0;
        lfsr_state = 32'h9a0d84fc;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = NOP_WORD[8*(i%4) +: 8];
        end
        repeat (4) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        @(posedge clk);
        #DRV_DLY;

        test_reset_contents();
        test_word_round_trip();
        test_partial_stores();
        test_misalign();
        test_addr_arith();
        test_random_stream(200);

        if (n_req != n_rsp) begin
            errors++;
            $display("%0d requests were issued but %0d responses came back", n_req, n_rsp);
        end
        $display("errors=%0d timeouts=%0d checks=%0d requests=%0d responses=%0d",
                 errors, timeouts, checks, n_req, n_rsp);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: lsu_top.f
verilog/lsu_pkg.sv
verilog/lsu_agen.sv
verilog/data_mem.sv
verilog/load_align.sv
verilog/lsu_top.sv
testbench/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - verilog/lsu_pkg.sv
  - verilog/lsu_agen.sv
  - verilog/data_mem.sv
  - verilog/load_align.sv
  - verilog/lsu_top.sv
  - target: test
    files:
      - testbench/lsu_tb.sv
